/* filelist.f */
+incdir+hw
hw/csr_pkg.sv
hw/csr_if.sv
hw/csr_write_modify.sv
hw/csr_machine_regs.sv
hw/csr_counters.sv
hw/csr_irq_ctrl.sv
hw/csr_read_mux.sv
hw/csr_top.sv
tb/tb_clk_gen.sv
tb/tb_csr_top.sv

/* tb/tb_csr_top.sv */
/*
 * Testbench for the machine-mode CSR bank
 * Directed and random stimulus, counter reference model,
 * concurrent checks on reads, outputs and interrupt timing
 */

`include "csr_cfg.svh"

module tb_csr_top;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int TIMEOUT_CYCLES = 600;   // About 200 cycles of tests plus margin
    localparam int OUT_MTVEC = 0;
    localparam int OUT_MEPC  = 1;
    localparam int OUT_PRIV  = 2;

    logic        clk, reset_n;
    logic        read_enable_i, write_enable_i;
    csr_op_e     operation_i;
    logic [11:0] address_i;
    logic [31:0] data_i, pc_i, next_pc_i, instruction_i, jump_target_i, irq_i;
    logic        raise_exception_i, machine_return_i, jump_i;
    logic        instr_valid_i, interrupt_ack_i;
    exc_code_e   exception_code_i;
    logic [63:0] mtime_i;
    logic [31:0] read_data_o, mepc_o, mtvec_o;
    logic        interrupt_pending_o;
    priv_e       privilege_o;

    int          seed = 32'h302c;
    int          errors, checks, cycles;
    string       test_name = "reset";
    logic [31:0] rd_exp, out_exp, out_act;
    logic        rd_cnt, out_chk, irq_chk;
    int          out_sel;
    logic [63:0] mcycle_m, minstret_m;   // Counter reference

    // Registers of the random access test: mscratch, mie, mstatus
    logic [11:0] rw_addr [3] = '{CSR_MSCRATCH, CSR_MIE, CSR_MSTATUS};
    logic [31:0] rw_mask [3] = '{32'hFFFF_FFFF, `CSR_MIE_WMASK, `CSR_MSTATUS_WMASK};
    logic [31:0] rw_shadow [3] = '{32'h0, 32'h0, 32'h0000_1800};   // mpp resets to M

    tb_clk_gen i_clk_gen (.clk(clk), .reset_n(reset_n));

    csr_top i_csr_top (.*);

    ////////////////////
    // Reference counters

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_m   <= '0;
            minstret_m <= '0;
        end else begin
            // Counters are written with CSR_WRITE only
            if (write_enable_i && address_i == CSR_MCYCLE)
                mcycle_m[31:0] <= data_i;
            else if (write_enable_i && address_i == CSR_MCYCLEH)
                mcycle_m[63:32] <= data_i;
            else
                mcycle_m <= mcycle_m + 1;
            if (instr_valid_i)
                minstret_m <= minstret_m + 1;
        end
    end

    function automatic logic [31:0] cnt_view(input logic [11:0] addr);
        case (addr)
            CSR_MCYCLE, CSR_CYCLE:     return mcycle_m[31:0];
            CSR_MCYCLEH, CSR_CYCLEH:   return mcycle_m[63:32];
            CSR_MINSTRET, CSR_INSTRET: return minstret_m[31:0];
            default:                   return minstret_m[63:32];
        endcase
    endfunction

    always_comb begin
        case (out_sel)
            OUT_MTVEC: out_act = mtvec_o;
            OUT_MEPC:  out_act = mepc_o;
            default:   out_act = 32'(privilege_o);
        endcase
    end

    ////////////////////
    // Checks

    a_read_value: assert property (@(negedge clk) disable iff (!reset_n)
        read_enable_i |-> read_data_o == (rd_cnt ? cnt_view(address_i) : rd_exp))
    else begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", test_name,
                 rd_cnt ? cnt_view(address_i) : rd_exp, read_data_o);
    end

    a_read_idle: assert property (@(negedge clk) disable iff (!reset_n)
        !read_enable_i |-> read_data_o == '0)
    else begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", test_name, 32'h0, read_data_o);
    end

    a_output: assert property (@(negedge clk) out_chk |-> out_act == out_exp)
    else begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", test_name, out_exp, out_act);
    end

    // Two edges from irq_i to the pending flag
    a_pend_delay: assert property (@(posedge clk) disable iff (!reset_n)
        irq_chk && $rose(irq_i[3]) |-> !interrupt_pending_o [*2] ##1 interrupt_pending_o)
    else begin
        errors++;
        $display("ERROR %s: pending flag did not rise two cycles after irq_i", test_name);
    end

    a_pend_after_ack: assert property (@(posedge clk) disable iff (!reset_n)
        interrupt_ack_i |=> !interrupt_pending_o)
    else begin
        errors++;
        $display("ERROR %s: pending flag still high after acknowledge", test_name);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run(1'b1);
        end
    end

    ////////////////////
    // Bus tasks

    task automatic write_csr(input csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] data);
        @(posedge clk);
        write_enable_i <= 1'b1;
        operation_i    <= op;
        address_i      <= addr;
        data_i         <= data;
        @(posedge clk);
        write_enable_i <= 1'b0;
    endtask

    // Expected value from the counter reference when from_model is set
    task automatic read_csr(input logic [11:0] addr, input logic [31:0] exp,
                            input logic from_model);
        @(posedge clk);
        read_enable_i <= 1'b1;
        address_i     <= addr;
        rd_exp        <= exp;
        rd_cnt        <= from_model;
        checks++;
        @(posedge clk);
        read_enable_i <= 1'b0;
    endtask

    task automatic check_output(input int sel, input logic [31:0] exp);
        @(posedge clk);
        out_sel <= sel;
        out_exp <= exp;
        out_chk <= 1'b1;
        checks++;
        @(posedge clk);
        out_chk <= 1'b0;
    endtask

    task automatic raise_exc(input exc_code_e code, input logic [31:0] pc,
                             input logic [31:0] instr);
        @(posedge clk);
        raise_exception_i <= 1'b1;
        exception_code_i  <= code;
        pc_i              <= pc;
        instruction_i     <= instr;
        @(posedge clk);
        raise_exception_i <= 1'b0;
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (!timed_out && errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    ////////////////////
    // Stimulus

    initial begin
        int          idx;
        int          k;
        csr_op_e     op;
        logic [31:0] data, mask, pc, instr, target;
        logic [63:0] mtime;

        read_enable_i     <= 1'b0;
        write_enable_i    <= 1'b0;
        operation_i       <= CSR_WRITE;
        address_i         <= '0;
        data_i            <= '0;
        raise_exception_i <= 1'b0;
        machine_return_i  <= 1'b0;
        exception_code_i  <= EXC_INSTR_MISALIGNED;
        pc_i              <= '0;
        next_pc_i         <= '0;
        instruction_i     <= '0;
        jump_i            <= 1'b0;
        jump_target_i     <= '0;
        instr_valid_i     <= 1'b0;
        mtime_i           <= '0;
        irq_i             <= '0;
        interrupt_ack_i   <= 1'b0;
        rd_exp            <= '0;
        rd_cnt            <= 1'b0;
        out_exp           <= '0;
        out_sel           <= OUT_MTVEC;
        out_chk           <= 1'b0;
        irq_chk           <= 1'b0;
        wait (reset_n);

        // WRITE, SET and CLEAR under the write masks
        test_name = "write_set_clear";
        for (int i = 0; i < 12; i++) begin
            idx  = {$random(seed)} % 3;
            data = $random(seed);
            mask = rw_mask[idx];
            case ({$random(seed)} % 3)
                0:       op = CSR_WRITE;
                1:       op = CSR_SET;
                default: op = CSR_CLEAR;
            endcase
            case (op)
                CSR_WRITE: rw_shadow[idx] = (rw_shadow[idx] & ~mask) | (data & mask);
                CSR_SET:   rw_shadow[idx] = rw_shadow[idx] | (data & mask);
                default:   rw_shadow[idx] = rw_shadow[idx] & ~(data & mask);
            endcase
            if (idx == 2 && rw_shadow[idx][12:11] != 2'b00)
                rw_shadow[idx][12:11] = 2'b11;   // mpp holds only U or M
            write_csr(op, rw_addr[idx], data);
            read_csr(rw_addr[idx], rw_shadow[idx], 1'b0);
        end

        test_name = "align_fixed";
        read_csr(CSR_MISA, `CSR_MISA_RESET, 1'b0);
        write_csr(CSR_WRITE, CSR_MTVEC, '1);
        read_csr(CSR_MTVEC, `CSR_ALIGN_WMASK, 1'b0);
        check_output(OUT_MTVEC, `CSR_ALIGN_WMASK);
        write_csr(CSR_WRITE, CSR_MEPC, '1);
        read_csr(CSR_MEPC, `CSR_ALIGN_WMASK, 1'b0);
        check_output(OUT_MEPC, `CSR_ALIGN_WMASK);
        for (int a = 12'hF11; a <= 12'hF15; a++)
            read_csr(12'(a), 32'h0, 1'b0);   // ID block

        test_name = "exception";
        write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_1808);   // mpp M, mie 1
        pc    = $random(seed) & 32'hFFFF_FFFC;
        instr = $random(seed);
        raise_exc(EXC_ILLEGAL_INSTR, pc, instr);
        read_csr(CSR_MEPC, pc, 1'b0);
        read_csr(CSR_MTVAL, instr, 1'b0);
        read_csr(CSR_MCAUSE, 32'd2, 1'b0);
        read_csr(CSR_MSTATUS, 32'h0000_1880, 1'b0);   // mpie 1, mie 0
        check_output(OUT_PRIV, 32'(PRIV_MACHINE));
        pc = $random(seed) & 32'hFFFF_FFFC;
        raise_exc(EXC_ECALL_M, pc, instr);
        read_csr(CSR_MTVAL, pc, 1'b0);   // Not an illegal instruction
        read_csr(CSR_MCAUSE, 32'd11, 1'b0);

        test_name = "mret";
        write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_0080);   // mpp U, mpie 1
        @(posedge clk);
        machine_return_i <= 1'b1;
        @(posedge clk);
        machine_return_i <= 1'b0;
        read_csr(CSR_MSTATUS, 32'h0000_0088, 1'b0);
        check_output(OUT_PRIV, 32'(PRIV_USER));

        test_name = "interrupt";
        write_csr(CSR_WRITE, CSR_MIE, 32'h0000_0088);   // msie and mtie
        target = $random(seed) & 32'hFFFF_FFFC;
        irq_chk <= 1'b1;
        @(posedge clk);
        irq_i <= 32'h0000_0088;   // Software and timer together
        while (!interrupt_pending_o)
            @(posedge clk);
        interrupt_ack_i <= 1'b1;
        jump_i          <= 1'b1;
        jump_target_i   <= target;
        next_pc_i       <= target + 32'd4;
        @(posedge clk);
        interrupt_ack_i <= 1'b0;
        jump_i          <= 1'b0;
        irq_i           <= '0;
        irq_chk         <= 1'b0;
        read_csr(CSR_MCAUSE, 32'h8000_0003, 1'b0);   // Software beats timer
        read_csr(CSR_MEPC, target, 1'b0);
        read_csr(CSR_MSTATUS, 32'h0000_0080, 1'b0);   // Trap taken from U
        check_output(OUT_PRIV, 32'(PRIV_MACHINE));

        test_name = "counters";
        data = $random(seed);
        write_csr(CSR_WRITE, CSR_MCYCLEH, data);
        read_csr(CSR_MCYCLEH, data, 1'b0);
        write_csr(CSR_WRITE, CSR_MCYCLE, 32'h0000_1000);
        read_csr(CSR_MCYCLE, 32'h0, 1'b1);
        k = 3 + {$random(seed)} % 8;
        repeat (k) begin
            @(posedge clk);
            instr = $random(seed);
            instr_valid_i <= instr[0];
        end
        read_csr(CSR_MCYCLE, 32'h0, 1'b1);
        read_csr(CSR_CYCLE, 32'h0, 1'b1);
        read_csr(CSR_MINSTRET, 32'h0, 1'b1);
        read_csr(CSR_INSTRETH, 32'h0, 1'b1);
        mtime[31:0]  = $random(seed);
        mtime[63:32] = $random(seed);
        @(posedge clk);
        mtime_i <= mtime;
        read_csr(CSR_TIME, mtime[31:0], 1'b0);
        read_csr(CSR_TIMEH, mtime[63:32], 1'b0);

        repeat (2) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

/* tb/tb_clk_gen.sv */
/*
 * Clock and reset source for the testbench
 * 10 ns clock, active-low reset over the first 5 cycles
 */

module tb_clk_gen (
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;   // Released on the 5th rising edge
    end

endmodule

/* hw/csr_top.sv */
/*
 * Machine-mode CSR bank, top level
 * Instances of the write, register, counter, interrupt and read blocks
 */

`include "csr_cfg.svh"

module csr_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 read_enable_i,
    input  logic                 write_enable_i,
    input  csr_pkg::csr_op_e     operation_i,
    input  logic [11:0]          address_i,
    input  logic [`CSR_XLEN-1:0] data_i,
    input  logic                 raise_exception_i,
    input  logic                 machine_return_i,
    input  csr_pkg::exc_code_e   exception_code_i,
    input  logic [`CSR_XLEN-1:0] pc_i,
    input  logic [`CSR_XLEN-1:0] next_pc_i,
    input  logic [`CSR_XLEN-1:0] instruction_i,
    input  logic                 jump_i,
    input  logic [`CSR_XLEN-1:0] jump_target_i,
    input  logic                 instr_valid_i,
    input  logic [63:0]          mtime_i,
    input  logic [`CSR_XLEN-1:0] irq_i,
    input  logic                 interrupt_ack_i,
    output logic [`CSR_XLEN-1:0] read_data_o,
    output logic                 interrupt_pending_o,
    output csr_pkg::priv_e       privilege_o,
    output logic [`CSR_XLEN-1:0] mepc_o,
    output logic [`CSR_XLEN-1:0] mtvec_o
);

    csr_wr_if    wr_bus ();
    csr_state_if state_bus ();
    csr_trap_if  trap_bus ();

    assign trap_bus.take = interrupt_ack_i;   // Seen by regs and irq control

    csr_write_modify i_write_modify (
        .clk(clk), .reset_n(reset_n), .write_enable_i(write_enable_i),
        .operation_i(operation_i), .address_i(address_i), .data_i(data_i), .wr(wr_bus)
    );

    csr_machine_regs i_machine_regs (
        .clk(clk), .reset_n(reset_n), .wr(wr_bus), .st(state_bus), .trap(trap_bus),
        .raise_exception_i(raise_exception_i), .machine_return_i(machine_return_i),
        .exception_code_i(exception_code_i), .pc_i(pc_i), .next_pc_i(next_pc_i),
        .instruction_i(instruction_i), .jump_i(jump_i), .jump_target_i(jump_target_i),
        .privilege_o(privilege_o), .mepc_o(mepc_o), .mtvec_o(mtvec_o)
    );

    csr_counters i_counters (
        .clk(clk), .reset_n(reset_n), .wr(wr_bus),
        .instr_valid_i(instr_valid_i), .st(state_bus)
    );

    csr_irq_ctrl i_irq_ctrl (
        .clk(clk), .reset_n(reset_n), .irq_i(irq_i), .trap(trap_bus),
        .st(state_bus), .interrupt_pending_o(interrupt_pending_o)
    );

    csr_read_mux i_read_mux (
        .read_enable_i(read_enable_i), .address_i(address_i), .mtime_i(mtime_i),
        .st(state_bus), .wr(wr_bus), .read_data_o(read_data_o)
    );

endmodule

/* hw/csr_read_mux.sv */
/*
 * CSR read decode
 * Read data for the core and current value for the write path
 */

`include "csr_cfg.svh"

module csr_read_mux (
    input  logic                 read_enable_i,
    input  logic [11:0]          address_i,
    input  logic [63:0]          mtime_i,
    csr_state_if.reader          st,
    csr_wr_if.source             wr,
    output logic [`CSR_XLEN-1:0] read_data_o
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] sel_val;

    always_comb begin
        case (csr_addr_e'(address_i))
            CSR_MSTATUS:                 sel_val = st.mstatus;
            CSR_MISA:                    sel_val = st.misa;
            CSR_MIE:                     sel_val = st.mie;
            CSR_MTVEC:                   sel_val = st.mtvec;
            CSR_MSCRATCH:                sel_val = st.mscratch;
            CSR_MEPC:                    sel_val = st.mepc;
            CSR_MCAUSE:                  sel_val = st.mcause;
            CSR_MTVAL:                   sel_val = st.mtval;
            CSR_MIP:                     sel_val = st.mip;
            // Counter halves and their user aliases
            CSR_MCYCLE, CSR_CYCLE:       sel_val = st.mcycle[`CSR_XLEN-1:0];
            CSR_MCYCLEH, CSR_CYCLEH:     sel_val = st.mcycle[63:`CSR_XLEN];
            CSR_MINSTRET, CSR_INSTRET:   sel_val = st.minstret[`CSR_XLEN-1:0];
            CSR_MINSTRETH, CSR_INSTRETH: sel_val = st.minstret[63:`CSR_XLEN];
            CSR_TIME:                    sel_val = mtime_i[`CSR_XLEN-1:0];
            CSR_TIMEH:                   sel_val = mtime_i[63:`CSR_XLEN];
            default:                     sel_val = '0;   // ID block reads zero
        endcase
    end

    assign wr.cur_val  = sel_val;
    assign read_data_o = read_enable_i ? sel_val : '0;

endmodule

/* hw/csr_irq_ctrl.sv */
/*
 * Interrupt control
 * mip sampling, pending flag, cause priority ext > sw > timer
 */

`include "csr_cfg.svh"

module csr_irq_ctrl (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [`CSR_XLEN-1:0] irq_i,
    csr_trap_if.irq              trap,
    csr_state_if.owner_irq       st,
    output logic                 interrupt_pending_o
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] mip;
    logic [`CSR_XLEN-1:0] active;   // Enabled and pending lines
    irq_code_e            cause;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            mip <= '0;
        else
            mip <= irq_i;
    end

    assign active = trap.enables & mip;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            interrupt_pending_o <= 1'b0;
            cause               <= IRQ_NONE;
        end else if (trap.global_ie && (active != '0) && !trap.take) begin
            interrupt_pending_o <= 1'b1;
            if (active[11])      cause <= IRQ_M_EXT;
            else if (active[3])  cause <= IRQ_M_SW;
            else if (active[7])  cause <= IRQ_M_TIMER;
        end else begin
            interrupt_pending_o <= 1'b0;   // Cause kept for the trap entry
        end
    end

    assign st.mip     = mip;
    assign trap.cause = cause;

    // An acknowledged interrupt must not be offered again right away
    a_no_pend_after_take: assert property (@(posedge clk) disable iff (!reset_n)
        trap.take |=> !interrupt_pending_o);

endmodule

/* hw/csr_counters.sv */
/*
 * 64-bit mcycle and minstret counters
 * Writable by halves, otherwise counting
 */

`include "csr_cfg.svh"

module csr_counters (
    input  logic           clk,
    input  logic           reset_n,
    csr_wr_if.sink         wr,
    input  logic           instr_valid_i,   // Retiring instruction this cycle
    csr_state_if.owner_cnt st
);
    import csr_pkg::*;

    logic [2*`CSR_XLEN-1:0] mcycle, minstret;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (wr.wr_en && wr.addr == CSR_MCYCLE)
                mcycle[`CSR_XLEN-1:0] <= wr.wdata;
            else if (wr.wr_en && wr.addr == CSR_MCYCLEH)
                mcycle[2*`CSR_XLEN-1:`CSR_XLEN] <= wr.wdata;
            else
                mcycle <= mcycle + 1'b1;

            if (wr.wr_en && wr.addr == CSR_MINSTRET)
                minstret[`CSR_XLEN-1:0] <= wr.wdata;
            else if (wr.wr_en && wr.addr == CSR_MINSTRETH)
                minstret[2*`CSR_XLEN-1:`CSR_XLEN] <= wr.wdata;
            else if (instr_valid_i)
                minstret <= minstret + 1'b1;
        end
    end

    assign st.mcycle   = mcycle;
    assign st.minstret = minstret;

endmodule

/* hw/csr_machine_regs.sv */
/*
 * Machine-mode trap registers and privilege level
 * mstatus fields, misa, mie, mtvec, mscratch, mepc, mcause, mtval
 * Update order: mret, exception, interrupt, CSR write
 */

`include "csr_cfg.svh"

module csr_machine_regs (
    input  logic                 clk,
    input  logic                 reset_n,
    csr_wr_if.sink               wr,
    csr_state_if.owner_regs      st,
    csr_trap_if.regs             trap,
    input  logic                 raise_exception_i,
    input  logic                 machine_return_i,
    input  csr_pkg::exc_code_e   exception_code_i,
    input  logic [`CSR_XLEN-1:0] pc_i,
    input  logic [`CSR_XLEN-1:0] next_pc_i,
    input  logic [`CSR_XLEN-1:0] instruction_i,
    input  logic                 jump_i,
    input  logic [`CSR_XLEN-1:0] jump_target_i,
    output csr_pkg::priv_e       privilege_o,
    output logic [`CSR_XLEN-1:0] mepc_o,
    output logic [`CSR_XLEN-1:0] mtvec_o
);
    import csr_pkg::*;

    priv_e                privilege;
    priv_e                mstatus_mpp;
    logic                 mstatus_mpie;
    logic                 mstatus_mie;
    logic [`CSR_XLEN-1:0] misa, mie, mtvec, mscratch, mepc, mcause, mtval;

    ////////////////////
    // Register updates

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            privilege    <= PRIV_MACHINE;
            mstatus_mpp  <= PRIV_MACHINE;
            mstatus_mpie <= 1'b0;
            mstatus_mie  <= 1'b0;
            misa         <= `CSR_MISA_RESET;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else if (machine_return_i) begin
            mstatus_mie <= mstatus_mpie;
            privilege   <= mstatus_mpp;
        end else if (raise_exception_i || trap.take) begin
            // Common trap entry
            mstatus_mpp  <= privilege;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            privilege    <= PRIV_MACHINE;
            if (raise_exception_i) begin
                mcause <= {1'b0, {(`CSR_XLEN-6){1'b0}}, exception_code_i};
                mepc   <= pc_i;
                mtval  <= (exception_code_i == EXC_ILLEGAL_INSTR) ? instruction_i : pc_i;
            end else begin
                mcause <= {1'b1, {(`CSR_XLEN-6){1'b0}}, trap.cause};
                // Current instruction retires, so resume after it
                mepc   <= jump_i ? jump_target_i : next_pc_i;
            end
        end else if (wr.wr_en) begin
            case (wr.addr)
                CSR_MSTATUS: begin
                    // mpp is WARL, only U and M exist
                    mstatus_mpp  <= (wr.wdata[12:11] == 2'b00) ? PRIV_USER : PRIV_MACHINE;
                    mstatus_mpie <= wr.wdata[7];
                    mstatus_mie  <= wr.wdata[3];
                end
                CSR_MISA:     misa     <= wr.wdata;
                CSR_MIE:      mie      <= wr.wdata;
                CSR_MTVEC:    mtvec    <= wr.wdata;
                CSR_MSCRATCH: mscratch <= wr.wdata;
                CSR_MEPC:     mepc     <= wr.wdata;
                CSR_MCAUSE:   mcause   <= wr.wdata;
                CSR_MTVAL:    mtval    <= wr.wdata;
                default: ;   // Counters live elsewhere
            endcase
        end
    end

    ////////////////////
    // Outputs

    assign st.mstatus = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign st.misa     = misa;
    assign st.mie      = mie;
    assign st.mtvec    = mtvec;
    assign st.mscratch = mscratch;
    assign st.mepc     = mepc;
    assign st.mcause   = mcause;
    assign st.mtval    = mtval;

    assign trap.global_ie = mstatus_mie;
    assign trap.enables   = mie;

    assign privilege_o = privilege;
    assign mepc_o      = mepc;
    assign mtvec_o     = mtvec;

    // Pipeline must not retire an mret that also faults
    a_no_ret_with_exc: assert property (@(posedge clk) disable iff (!reset_n)
        !(raise_exception_i && machine_return_i));

endmodule

/* hw/csr_write_modify.sv */
/*
 * Write-data generation
 * Per-address write mask and WRITE/SET/CLEAR combination
 */

`include "csr_cfg.svh"

module csr_write_modify (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 write_enable_i,
    input  csr_pkg::csr_op_e     operation_i,
    input  logic [11:0]          address_i,
    input  logic [`CSR_XLEN-1:0] data_i,
    csr_wr_if.modifier           wr
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] wmask;

    assign wr.wr_en = write_enable_i;
    assign wr.addr  = csr_addr_e'(address_i);

    always_comb begin
        case (wr.addr)
            CSR_MSTATUS:             wmask = `CSR_MSTATUS_WMASK;
            CSR_MISA:                wmask = `CSR_MISA_WMASK;
            CSR_MIE:                 wmask = `CSR_MIE_WMASK;
            CSR_MTVEC, CSR_MEPC:     wmask = `CSR_ALIGN_WMASK;
            CSR_MSCRATCH, CSR_MCAUSE, CSR_MTVAL,
            CSR_MCYCLE, CSR_MCYCLEH,
            CSR_MINSTRET, CSR_MINSTRETH: wmask = '1;
            default:                 wmask = '0;   // Read-only or absent
        endcase
    end

    always_comb begin
        case (operation_i)
            CSR_SET:   wr.wdata = wr.cur_val | (data_i & wmask);
            CSR_CLEAR: wr.wdata = wr.cur_val & ~(data_i & wmask);
            default:   wr.wdata = (wr.cur_val & ~wmask) | (data_i & wmask);
        endcase
    end

    // Decoder upstream must never issue the reserved op code
    a_legal_op: assert property (@(posedge clk) disable iff (!reset_n)
        wr.wr_en |-> operation_i inside {CSR_WRITE, CSR_SET, CSR_CLEAR});

endmodule

/* hw/csr_if.sv */
/*
 * Internal buses of the CSR bank
 * csr_wr_if (write path), csr_state_if (register values),
 * csr_trap_if (interrupt decision)
 */

`include "csr_cfg.svh"

interface csr_wr_if;
    import csr_pkg::*;

    logic                 wr_en;
    csr_addr_e            addr;
    logic [`CSR_XLEN-1:0] wdata;     // Already masked and combined
    logic [`CSR_XLEN-1:0] cur_val;   // Raw value at addr

    modport modifier (output wr_en, addr, wdata, input cur_val);
    modport source   (output cur_val);
    modport sink     (input wr_en, addr, wdata);
endinterface

interface csr_state_if;
    logic [`CSR_XLEN-1:0] mstatus, misa, mie, mtvec, mscratch;
    logic [`CSR_XLEN-1:0] mepc, mcause, mtval, mip;
    logic [63:0]          mcycle, minstret;

    modport owner_regs (output mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mtval);
    modport owner_cnt  (output mcycle, minstret);
    modport owner_irq  (output mip);
    modport reader     (input mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mtval,
                        mip, mcycle, minstret);
endinterface

interface csr_trap_if;
    import csr_pkg::*;

    logic                 global_ie;   // mstatus.mie
    logic [`CSR_XLEN-1:0] enables;     // mie register
    irq_code_e            cause;
    logic                 take;        // Core acknowledges the interrupt

    modport regs (output global_ie, enables, input cause, take);
    modport irq  (input global_ie, enables, take, output cause);
endinterface

/* hw/csr_pkg.sv */
/*
 * Shared types of the CSR bank
 * Addresses, operations, privilege levels, exception and interrupt codes
 */

package csr_pkg;

    // Implemented CSR addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MCYCLE     = 12'hB00,
        CSR_MINSTRET   = 12'hB02,
        CSR_MCYCLEH    = 12'hB80,
        CSR_MINSTRETH  = 12'hB82,
        CSR_CYCLE      = 12'hC00,   // User read-only aliases
        CSR_TIME       = 12'hC01,
        CSR_INSTRET    = 12'hC02,
        CSR_CYCLEH     = 12'hC80,
        CSR_TIMEH      = 12'hC81,
        CSR_INSTRETH   = 12'hC82,
        CSR_MVENDORID  = 12'hF11,   // Machine ID block
        CSR_MARCHID    = 12'hF12,
        CSR_MIMPID     = 12'hF13,
        CSR_MHARTID    = 12'hF14,
        CSR_MCONFIGPTR = 12'hF15
    } csr_addr_e;

    // Same coding as funct3[1:0] of CSRRW/CSRRS/CSRRC
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED = 5'd0,
        EXC_INSTR_FAULT      = 5'd1,
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_LOAD_FAULT       = 5'd5,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_STORE_FAULT      = 5'd7,
        EXC_ECALL_U          = 5'd8,
        EXC_ECALL_S          = 5'd9,
        EXC_ECALL_M          = 5'd11,
        EXC_INSTR_PAGE_FAULT = 5'd12,
        EXC_LOAD_PAGE_FAULT  = 5'd13,
        EXC_STORE_PAGE_FAULT = 5'd15
    } exc_code_e;

    typedef enum logic [4:0] {
        IRQ_NONE    = 5'd0,
        IRQ_M_SW    = 5'd3,
        IRQ_M_TIMER = 5'd7,
        IRQ_M_EXT   = 5'd11
    } irq_code_e;

endpackage

/* hw/csr_cfg.svh */
/*
 * Build-time configuration of the CSR bank
 * Register width, compressed-ISA option, write masks, misa reset value
 */

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN 32

// 1 when the core executes 16-bit instructions
`define CSR_COMPRESSED 0

////////////////////
// Write masks
`define CSR_MSTATUS_WMASK 32'h0000_1888   // mpp, mpie, mie
`define CSR_MIE_WMASK     32'h0000_0888   // meie, mtie, msie
`define CSR_ALIGN_WMASK   ((`CSR_COMPRESSED) ? 32'hFFFF_FFFE : 32'hFFFF_FFFC)
`define CSR_MISA_WMASK    32'h0010_1000   // M and U may be switched

////////////////////
// misa: MXL=1, I, M, U, plus C when compressed
`define CSR_MISA_RESET (32'h4010_1100 | ((`CSR_COMPRESSED) ? 32'h0000_0004 : 32'h0000_0000))

`endif
